// File: rtl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// word address and data word widths
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32

// banks, picked by the low address bit
`define CACHE_BANKS 2

// set index sits in address bits 4..1, above the bank bit
`define CACHE_WAYS 4
`define CACHE_SET_W 4

`define CACHE_ID_W 4

// request queue depth, same as the credits the requester starts with
`define CACHE_CREDITS 4

`endif

// File: rtl/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_DATA_W-1:0] data_t;
	typedef logic [`CACHE_SET_W-1:0] set_t;
	// address bits above set and bank fields
	typedef logic [`CACHE_ADDR_W-`CACHE_SET_W-2:0] line_tag_t;
	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
	typedef logic [$clog2(`CACHE_BANKS)-1:0] bank_t;
	typedef logic [`CACHE_ID_W-1:0] id_t;

	typedef struct packed {
		id_t   id;
		addr_t addr;
	} cache_req_t;

	typedef struct packed {
		id_t   id;
		data_t data;
		logic  hit;
	} cache_rsp_t;

	typedef struct packed {
		bank_t bank;
		addr_t addr;
	} mem_req_t;

	// miss handling in a bank
	typedef enum logic [1:0] {run, fetch, fill} bank_state_t;

endpackage

`default_nettype wire

// File: rtl/cache_tag_lru.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_tag_lru
	import cache_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire            stall,
	input  wire            clear_start,
	output logic           clear_busy,
	input  wire            in_valid,
	input  wire id_t       in_id,
	input  wire set_t      in_set,
	input  wire line_tag_t in_tag,
	output logic           out_valid,
	output id_t            out_id,
	output set_t           out_set,
	output way_t           out_way,
	output logic           out_hit
);

	localparam int WAYS = `CACHE_WAYS;
	localparam int SETS = 1 << `CACHE_SET_W;

	typedef struct packed {
		logic      valid;
		way_t      way;
		line_tag_t tag;
	} lru_entry_t;

	// entry 0 is the most recently used way
	typedef lru_entry_t [WAYS-1:0] lru_list_t;

	function automatic lru_list_t empty_list();
		lru_list_t l;
		for (int i = 0; i < WAYS; i++) begin
			l[i].valid = 1'b0;
			l[i].way = way_t'(i);
			l[i].tag = '0;
		end
		return l;
	endfunction

	lru_list_t mem [SETS];

	logic      st1_valid;
	id_t       st1_id;
	set_t      st1_set;
	line_tag_t st1_tag;
	logic      st1_fw2;
	logic      st1_fw3;
	lru_list_t st1_dout;
	lru_list_t st1_rdata;
	lru_list_t st1_next;
	logic      st1_hit;
	way_t      st1_pos;

	logic      st2_valid;
	id_t       st2_id;
	set_t      st2_set;
	logic      st2_hit;
	lru_list_t st2_list;
	lru_list_t st3_list;

	logic      clearing;
	set_t      clr_set;
	logic      mem_we;
	set_t      wr_set;
	lru_list_t wr_list;

	initial begin
		for (int s = 0; s < SETS; s++) begin
			mem[s] = empty_list();
		end
	end

	// ------------------------------------------------------------------
	// stage 1: forwarding, hit test, move to front
	// ------------------------------------------------------------------
	always_comb begin
		st1_rdata = st1_dout;
		// stage 2 is newer than stage 3
		if (st1_fw3) begin
			st1_rdata = st3_list;
		end
		if (st1_fw2) begin
			st1_rdata = st2_list;
		end
	end

	always_comb begin
		st1_hit = 1'b0;
		// no match means the oldest entry is the victim
		st1_pos = way_t'(WAYS - 1);
		for (int j = 0; j < WAYS; j++) begin
			if (st1_rdata[j].valid && st1_rdata[j].tag == st1_tag) begin
				st1_hit = 1'b1;
				st1_pos = way_t'(j);
			end
		end
	end

	always_comb begin
		st1_next = st1_rdata;
		st1_next[0].valid = 1'b1;
		st1_next[0].way = st1_rdata[st1_pos].way;
		st1_next[0].tag = st1_tag;
		// entries ahead of the chosen one slide back by one
		for (int j = 1; j < WAYS; j++) begin
			if (j <= int'(st1_pos)) begin
				st1_next[j] = st1_rdata[j-1];
			end
		end
	end

	// ------------------------------------------------------------------
	// write back, clear walk
	// ------------------------------------------------------------------
	assign mem_we = clearing || (st2_valid && !stall);
	assign wr_set = clearing ? clr_set : st2_set;
	assign wr_list = clearing ? empty_list() : st2_list;

	always_ff @(posedge clk) begin
		if (reset) begin
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
			clearing <= 1'b0;
			clr_set <= '0;
		end else if (clear_start) begin
			// flush the pipe and restart the walk at set 0
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
			clearing <= 1'b1;
			clr_set <= '0;
		end else begin
			if (!stall) begin
				st1_valid <= in_valid;
				st2_valid <= st1_valid;
			end
			if (clearing) begin
				clr_set <= clr_set + 1'b1;
				if (clr_set == '1) begin
					clearing <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			st1_id <= in_id;
			st1_set <= in_set;
			st1_tag <= in_tag;
			st1_fw2 <= st1_valid && (in_set == st1_set);
			st1_fw3 <= st2_valid && (in_set == st2_set);
			st1_dout <= mem[in_set];
			st2_id <= st1_id;
			st2_set <= st1_set;
			st2_hit <= st1_hit;
			st2_list <= st1_next;
		end
		if (mem_we) begin
			mem[wr_set] <= wr_list;
			st3_list <= wr_list;
		end
	end

	assign clear_busy = clearing;
	assign out_valid = st2_valid;
	assign out_id = st2_id;
	assign out_set = st2_set;
	assign out_way = st2_list[0].way;
	assign out_hit = st2_hit;

endmodule

`default_nettype wire

// File: rtl/cache_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_bank
	import cache_pkg::*;
#(
	parameter bank_t BANK_ID = '0
) (
	input  wire             clk,
	input  wire             reset,
	input  wire             clear_start,
	output logic            clear_busy,
	input  wire             req_valid,
	input  wire cache_req_t req,
	output logic            req_ready,
	output logic            rsp_valid,
	output cache_rsp_t      rsp,
	input  wire             rsp_ready,
	output logic            mem_req_valid,
	output mem_req_t        mem_req,
	input  wire             mem_ack,
	input  wire             mem_rvalid,
	input  wire data_t      mem_rdata
);

	localparam int LINES = (1 << `CACHE_SET_W) * `CACHE_WAYS;
	localparam int BANK_W = $bits(bank_t);

	bank_state_t state;

	logic      stall;
	logic      tag_in_valid;
	logic      out_valid;
	id_t       out_id;
	set_t      out_set;
	way_t      out_way;
	logic      out_hit;

	logic      out_free;
	logic      hit_go;
	logic      fill_go;
	logic      fill_have;
	data_t     fill_word;
	data_t     hit_data;
	addr_t     p1_addr;
	addr_t     p2_addr;

	logic [$bits(set_t)+$bits(way_t)-1:0] line_idx;

	data_t data_mem [LINES];

	assign tag_in_valid = req_valid && req_ready;

	cache_tag_lru u_tag (
		.clk        (clk),
		.reset      (reset),
		.stall      (stall),
		.clear_start(clear_start),
		.clear_busy (clear_busy),
		.in_valid   (tag_in_valid),
		.in_id      (req.id),
		.in_set     (req.addr[BANK_W +: $bits(set_t)]),
		.in_tag     (req.addr[BANK_W + $bits(set_t) +: $bits(line_tag_t)]),
		.out_valid  (out_valid),
		.out_id     (out_id),
		.out_set    (out_set),
		.out_way    (out_way),
		.out_hit    (out_hit)
	);

	// ------------------------------------------------------------------
	// retire control
	// ------------------------------------------------------------------
	always_comb begin
		out_free = !rsp_valid || rsp_ready;
		hit_go = (state == run) && out_valid && out_hit && out_free;
		// refill word may arrive now or may already be parked
		fill_go = (state == fill) && (mem_rvalid || fill_have) && out_free;
		stall = out_valid && !(hit_go || fill_go);
	end

	assign req_ready = !stall && !clear_busy;

	assign line_idx = {out_set, out_way};
	assign hit_data = data_mem[line_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= run;
			fill_have <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			case (state)
				run: begin
					if (out_valid && !out_hit) begin
						state <= fetch;
					end
				end
				fetch: begin
					if (mem_ack) begin
						state <= fill;
					end
				end
				fill: begin
					if (fill_go) begin
						state <= run;
					end
				end
				default: begin
					state <= run;
				end
			endcase

			if (fill_go) begin
				fill_have <= 1'b0;
			end else if (mem_rvalid) begin
				fill_have <= 1'b1;
			end

			if (hit_go || fill_go) begin
				rsp_valid <= 1'b1;
			end else if (rsp_ready) begin
				rsp_valid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// address shadow, data store, response register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		// follows the tag pipeline so the miss address is at hand
		if (!stall) begin
			p1_addr <= req.addr;
			p2_addr <= p1_addr;
		end
		if (mem_rvalid) begin
			data_mem[line_idx] <= mem_rdata;
			fill_word <= mem_rdata;
		end
		if (hit_go || fill_go) begin
			rsp.id <= out_id;
			rsp.hit <= hit_go;
			if (hit_go) begin
				rsp.data <= hit_data;
			end else begin
				rsp.data <= fill_have ? fill_word : mem_rdata;
			end
		end
	end

	assign mem_req_valid = (state == fetch);
	assign mem_req.bank = BANK_ID;
	assign mem_req.addr = p2_addr;

endmodule

`default_nettype wire

// File: rtl/cache_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_dispatch
	import cache_pkg::*;
(
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        clear_busy,
	input  wire                        req_valid,
	input  wire cache_req_t            req,
	output logic                       req_credit,
	output logic [`CACHE_BANKS-1:0]    bank_req_valid,
	output cache_req_t                 bank_req,
	input  wire  [`CACHE_BANKS-1:0]    bank_req_ready
);

	localparam int DEPTH = `CACHE_CREDITS;
	localparam int PTR_W = $clog2(DEPTH);

	cache_req_t queue [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             pop;

	assign bank_req = queue[rd_ptr];

	// head goes only to the bank named by its low address bits
	always_comb begin
		for (int b = 0; b < `CACHE_BANKS; b++) begin
			bank_req_valid[b] = (count != '0) && !clear_busy &&
				(bank_t'(bank_req.addr) == bank_t'(b));
		end
	end

	assign pop = |(bank_req_valid & bank_req_ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			req_credit <= 1'b0;
		end else begin
			if (req_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + (req_valid ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
			req_credit <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			queue[wr_ptr] <= req;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cache_collect.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_collect
	import cache_pkg::*;
(
	input  wire                                clk,
	input  wire                                reset,
	input  wire  [`CACHE_BANKS-1:0]            bank_rsp_valid,
	input  wire cache_rsp_t [`CACHE_BANKS-1:0] bank_rsp,
	output logic [`CACHE_BANKS-1:0]            bank_rsp_ready,
	output logic                               rsp_valid,
	output cache_rsp_t                         rsp,
	input  wire  [`CACHE_BANKS-1:0]            bank_mem_valid,
	input  wire mem_req_t [`CACHE_BANKS-1:0]   bank_mem_req,
	output logic [`CACHE_BANKS-1:0]            bank_mem_ack,
	output logic                               mem_req_valid,
	output mem_req_t                           mem_req,
	input  wire                                mem_ack,
	input  wire                                mem_rvalid,
	input  wire bank_t                         mem_rbank,
	output logic [`CACHE_BANKS-1:0]            bank_mem_rvalid
);

	localparam int BANKS = `CACHE_BANKS;

	// first valid bank after the last one served
	function automatic bank_t rr_pick(input logic [BANKS-1:0] valid, input bank_t last);
		bank_t idx;
		rr_pick = last;
		for (int k = BANKS; k >= 1; k--) begin
			idx = bank_t'((int'(last) + k) % BANKS);
			if (valid[idx]) begin
				rr_pick = idx;
			end
		end
	endfunction

	bank_t rsp_last;
	bank_t rsp_sel;
	bank_t mem_sel;
	bank_t mem_owner;

	assign rsp_sel = rr_pick(bank_rsp_valid, rsp_last);
	assign mem_sel = rr_pick(bank_mem_valid, mem_owner);

	always_comb begin
		for (int b = 0; b < BANKS; b++) begin
			bank_rsp_ready[b] = (|bank_rsp_valid) && (rsp_sel == bank_t'(b));
			bank_mem_ack[b] = mem_ack && mem_req_valid && (mem_owner == bank_t'(b));
			bank_mem_rvalid[b] = mem_rvalid && (mem_rbank == bank_t'(b));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			rsp_last <= '0;
			mem_req_valid <= 1'b0;
			mem_owner <= '0;
		end else begin
			rsp_valid <= |bank_rsp_valid;
			if (|bank_rsp_valid) begin
				rsp_last <= rsp_sel;
			end
			// memory grant stays with one bank until the ack
			if (mem_req_valid) begin
				if (mem_ack) begin
					mem_req_valid <= 1'b0;
				end
			end else if (|bank_mem_valid) begin
				mem_req_valid <= 1'b1;
				mem_owner <= mem_sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		rsp <= bank_rsp[rsp_sel];
		if (!mem_req_valid) begin
			mem_req <= bank_mem_req[mem_sel];
		end
	end

endmodule

`default_nettype wire

// File: rtl/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_top
	import cache_pkg::*;
(
	input  wire             clk,
	input  wire             reset,
	input  wire             clear_start,
	output logic            clear_busy,
	input  wire             req_valid,
	input  wire cache_req_t req,
	output logic            req_credit,
	output logic            rsp_valid,
	output cache_rsp_t      rsp,
	output logic            mem_req_valid,
	output mem_req_t        mem_req,
	input  wire             mem_ack,
	input  wire             mem_rvalid,
	input  wire bank_t      mem_rbank,
	input  wire data_t      mem_rdata
);

	logic [`CACHE_BANKS-1:0]             bank_busy;
	logic [`CACHE_BANKS-1:0]             bank_req_valid;
	logic [`CACHE_BANKS-1:0]             bank_req_ready;
	cache_req_t                          bank_req;
	logic [`CACHE_BANKS-1:0]             bank_rsp_valid;
	logic [`CACHE_BANKS-1:0]             bank_rsp_ready;
	cache_rsp_t [`CACHE_BANKS-1:0]       bank_rsp;
	logic [`CACHE_BANKS-1:0]             bank_mem_valid;
	logic [`CACHE_BANKS-1:0]             bank_mem_ack;
	logic [`CACHE_BANKS-1:0]             bank_mem_rvalid;
	mem_req_t [`CACHE_BANKS-1:0]         bank_mem_req;

	assign clear_busy = |bank_busy;

	cache_dispatch u_dispatch (
		.clk           (clk),
		.reset         (reset),
		.clear_busy    (clear_busy),
		.req_valid     (req_valid),
		.req           (req),
		.req_credit    (req_credit),
		.bank_req_valid(bank_req_valid),
		.bank_req      (bank_req),
		.bank_req_ready(bank_req_ready)
	);

	for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
		cache_bank #(
			.BANK_ID(bank_t'(b))
		) u_bank (
			.clk          (clk),
			.reset        (reset),
			.clear_start  (clear_start),
			.clear_busy   (bank_busy[b]),
			.req_valid    (bank_req_valid[b]),
			.req          (bank_req),
			.req_ready    (bank_req_ready[b]),
			.rsp_valid    (bank_rsp_valid[b]),
			.rsp          (bank_rsp[b]),
			.rsp_ready    (bank_rsp_ready[b]),
			.mem_req_valid(bank_mem_valid[b]),
			.mem_req      (bank_mem_req[b]),
			.mem_ack      (bank_mem_ack[b]),
			.mem_rvalid   (bank_mem_rvalid[b]),
			.mem_rdata    (mem_rdata)
		);
	end

	cache_collect u_collect (
		.clk            (clk),
		.reset          (reset),
		.bank_rsp_valid (bank_rsp_valid),
		.bank_rsp       (bank_rsp),
		.bank_rsp_ready (bank_rsp_ready),
		.rsp_valid      (rsp_valid),
		.rsp            (rsp),
		.bank_mem_valid (bank_mem_valid),
		.bank_mem_req   (bank_mem_req),
		.bank_mem_ack   (bank_mem_ack),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_ack        (mem_ack),
		.mem_rvalid     (mem_rvalid),
		.mem_rbank      (mem_rbank),
		.bank_mem_rvalid(bank_mem_rvalid)
	);

endmodule

`default_nettype wire

// File: verif/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_tb
	import cache_pkg::*;
;

	localparam int SETS = 1 << `CACHE_SET_W;
	localparam int WAIT_LIMIT = 2000;

	logic       clk;
	logic       reset;
	logic       clear_start;
	logic       clear_busy;
	logic       req_valid;
	cache_req_t req;
	logic       req_credit;
	logic       rsp_valid;
	cache_rsp_t rsp;
	logic       mem_req_valid;
	mem_req_t   mem_req;
	logic       mem_ack;
	logic       mem_rvalid;
	bank_t      mem_rbank;
	data_t      mem_rdata;

	// backing memory image from the stimulus file
	data_t image [addr_t];

	// LRU reference with entry 0 the most recent
	line_tag_t lru_tag [`CACHE_BANKS][SETS][`CACHE_WAYS];
	logic      lru_valid [`CACHE_BANKS][SETS][`CACHE_WAYS];

	// expected response per id
	logic  exp_valid [1 << `CACHE_ID_W];
	logic  exp_hit [1 << `CACHE_ID_W];
	data_t exp_data [1 << `CACHE_ID_W];
	int    exp_bank [1 << `CACHE_ID_W];
	int    bank_q [`CACHE_BANKS][$];

	int    credits;
	int    sent;
	int    returned;
	int    answered;
	int    mem_reqs;
	int    checks;
	int    test_errors;
	int    total_errors;
	int    tests;
	int    tests_failed;
	int    misses_exp;
	int    mem_reqs_start;
	logic  hung;
	string cur_test;

	cache_top uut (
		.clk          (clk),
		.reset        (reset),
		.clear_start  (clear_start),
		.clear_busy   (clear_busy),
		.req_valid    (req_valid),
		.req          (req),
		.req_credit   (req_credit),
		.rsp_valid    (rsp_valid),
		.rsp          (rsp),
		.mem_req_valid(mem_req_valid),
		.mem_req      (mem_req),
		.mem_ack      (mem_ack),
		.mem_rvalid   (mem_rvalid),
		.mem_rbank    (mem_rbank),
		.mem_rdata    (mem_rdata)
	);

	always #5 clk = ~clk;

	function automatic data_t backing_word(input addr_t a);
		if (image.exists(a)) begin
			return image[a];
		end
		// unlisted words follow the address
		return {a ^ 16'h5a3c, ~a};
	endfunction

	function automatic logic model_access(input int b, input int s, input line_tag_t t);
		int   pos;
		logic hit;
		pos = `CACHE_WAYS - 1;
		hit = 1'b0;
		for (int i = 0; i < `CACHE_WAYS; i++) begin
			if (!hit && lru_valid[b][s][i] && lru_tag[b][s][i] == t) begin
				hit = 1'b1;
				pos = i;
			end
		end
		for (int i = pos; i > 0; i--) begin
			lru_tag[b][s][i] = lru_tag[b][s][i-1];
			lru_valid[b][s][i] = lru_valid[b][s][i-1];
		end
		lru_tag[b][s][0] = t;
		lru_valid[b][s][0] = 1'b1;
		return hit;
	endfunction

	function automatic void model_clear();
		for (int b = 0; b < `CACHE_BANKS; b++) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					lru_valid[b][s][w] = 1'b0;
					lru_tag[b][s][w] = '0;
				end
			end
		end
	endfunction

	task automatic error_msg(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
	endtask

	task automatic check_response();
		id_t id;
		int  b;
		id = rsp.id;
		checks++;
		if (!exp_valid[id]) begin
			error_msg($sformatf("response for id %0d with no request outstanding", id));
			return;
		end
		b = exp_bank[id];
		if (bank_q[b].size() == 0 || bank_q[b][0] != int'(id)) begin
			error_msg($sformatf("id %0d answered out of order in bank %0d", id, b));
		end
		for (int i = 0; i < bank_q[b].size(); i++) begin
			if (bank_q[b][i] == int'(id)) begin
				bank_q[b].delete(i);
				break;
			end
		end
		if (rsp.hit !== exp_hit[id]) begin
			$display("FAIL %s id %0d hit expected %0b actual %0b", cur_test, id,
				exp_hit[id], rsp.hit);
			test_errors++;
		end
		if (rsp.data !== exp_data[id]) begin
			$display("FAIL %s id %0d data expected %h actual %h", cur_test, id,
				exp_data[id], rsp.data);
			test_errors++;
		end
		exp_valid[id] = 1'b0;
		answered++;
	endtask

	// one clock with outputs read 1 ns after the edge
	task automatic step();
		@(posedge clk);
		#1;
		if (req_credit) begin
			checks++;
			if (returned >= sent) begin
				error_msg("credit returned with no request in flight");
			end
			credits++;
			returned++;
		end
		if (rsp_valid) begin
			check_response();
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (answered != sent && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (answered != sent) begin
			error_msg("timeout waiting for outstanding responses");
			hung = 1'b1;
		end
	endtask

	task automatic issue(input id_t id, input addr_t addr, input logic file_hit);
		int        n;
		int        b;
		logic      hit;
		n = 0;
		while (credits == 0 && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (credits == 0) begin
			error_msg("timeout waiting for a request credit");
			hung = 1'b1;
			return;
		end
		b = int'(addr[0]);
		hit = model_access(b, int'(addr[`CACHE_SET_W:1]), addr[`CACHE_ADDR_W-1:`CACHE_SET_W+1]);
		if (hit != file_hit) begin
			error_msg($sformatf("stimulus hit %0b for id %0d disagrees with LRU model",
				file_hit, id));
		end
		misses_exp += hit ? 0 : 1;
		exp_valid[id] = 1'b1;
		exp_hit[id] = hit;
		exp_data[id] = backing_word(addr);
		exp_bank[id] = b;
		bank_q[b].push_back(int'(id));
		req_valid = 1'b1;
		req.id = id;
		req.addr = addr;
		credits--;
		sent++;
		step();
		req_valid = 1'b0;
	endtask

	task automatic run_clear();
		int n;
		drain();
		clear_start = 1'b1;
		step();
		clear_start = 1'b0;
		model_clear();
		n = 0;
		while (clear_busy && n < 100) begin
			step();
			n++;
		end
		if (clear_busy) begin
			error_msg("clear_busy stayed high after a clear");
			hung = 1'b1;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
		misses_exp = 0;
		mem_reqs_start = mem_reqs;
	endtask

	task automatic finish_test();
		drain();
		checks += 2;
		if (mem_reqs - mem_reqs_start != misses_exp) begin
			$display("FAIL %s memory requests expected %0d actual %0d", cur_test,
				misses_exp, mem_reqs - mem_reqs_start);
			test_errors++;
		end
		if (returned != sent) begin
			$display("FAIL %s credits expected %0d actual %0d", cur_test, sent, returned);
			test_errors++;
		end
		$display("test %s: %0d errors", cur_test, test_errors);
		tests++;
		tests_failed += (test_errors != 0) ? 1 : 0;
		total_errors += test_errors;
	endtask

	// ------------------------------------------------------------------
	// memory model serving one access at a time
	// ------------------------------------------------------------------
	initial begin
		addr_t a;
		bank_t b;
		int    d;
		mem_ack = 1'b0;
		mem_rvalid = 1'b0;
		mem_rbank = '0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			#1;
			mem_ack = 1'b0;
			mem_rvalid = 1'b0;
			if (mem_req_valid === 1'b1) begin
				d = $urandom_range(3, 0);
				repeat (d) begin
					@(posedge clk);
					#1;
				end
				a = mem_req.addr;
				b = mem_req.bank;
				mem_ack = 1'b1;
				mem_reqs++;
				@(posedge clk);
				#1;
				mem_ack = 1'b0;
				// data lands 2 to 6 cycles after the ack
				d = $urandom_range(5, 1);
				repeat (d) begin
					@(posedge clk);
					#1;
				end
				mem_rvalid = 1'b1;
				mem_rbank = b;
				mem_rdata = backing_word(a);
			end
		end
	end

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		int          fd;
		string       line;
		string       tok;
		string       name;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		logic        in_test;
		void'($urandom(32'h79b0));
		clk = 1'b0;
		reset = 1'b1;
		clear_start = 1'b0;
		req_valid = 1'b0;
		req = '0;
		credits = `CACHE_CREDITS;
		{sent, returned, answered, mem_reqs, checks} = '0;
		{test_errors, total_errors, tests, tests_failed} = '0;
		hung = 1'b0;
		in_test = 1'b0;
		cur_test = "setup";
		for (int i = 0; i < (1 << `CACHE_ID_W); i++) begin
			exp_valid[i] = 1'b0;
		end
		model_clear();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		fd = $fopen("verif/cache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			hung = 1'b1;
		end
		while (!hung && $fgets(line, fd) != 0) begin
			if (line.len() > 0) begin
				case (line.getc(0))
					"M": begin
						void'($sscanf(line, "%s %h %h", tok, v1, v2));
						image[addr_t'(v1)] = v2;
					end
					"T": begin
						if (in_test) begin
							finish_test();
						end
						void'($sscanf(line, "%s %s", tok, name));
						start_test(name);
						in_test = 1'b1;
					end
					"A": begin
						void'($sscanf(line, "%s %h %h %h", tok, v1, v2, v3));
						issue(id_t'(v1), addr_t'(v2), v3[0]);
					end
					"C": begin
						run_clear();
					end
					default: begin
					end
				endcase
			end
		end
		if (in_test && !hung) begin
			finish_test();
		end else if (hung) begin
			total_errors += test_errors + 1;
		end
		$display("tests %0d failed %0d checks %0d errors %0d", tests, tests_failed,
			checks, total_errors);
		if (total_errors == 0 && tests > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/cache_stimulus.txt
# M addr data : backing memory word, other words follow the address
# T name : test start, A id addr hit : access and expected hit, C : clear
M 0010 deadbeef
M 0021 12345678
M 0026 0badf00d
M 0100 cafe0100
M 0345 a5a50345
T cold_then_hit
A 0 0010 0
A 1 0010 1
A 2 0021 0
A 3 0021 1
T lru_evict
A 0 0026 0
A 1 0046 0
A 2 0066 0
A 3 0086 0
A 4 00a6 0
A 5 0026 0
A 6 0066 1
A 7 0086 1
A 8 00a6 1
A 9 0026 1
T forwarding
A 0 002b 0
A 1 002b 1
A 2 004b 0
A 3 002b 1
A 4 004b 1
A 5 006b 0
A 6 006b 1
A 7 002b 1
T credit_flow
A 0 0010 1
A 1 0021 1
A 2 0026 1
A 3 002b 1
A 4 0010 1
A 5 0021 1
A 6 0066 1
A 7 006b 1
A 8 0086 1
A 9 004b 1
A a 00a6 1
A b 0010 1
T clear
C
A 0 0010 0
A 1 0021 0
A 2 0026 0
A 3 002b 0
A 4 0010 1
T interleave
A 0 0100 0
A 1 0101 0
A 2 0232 0
A 3 0233 0
A 4 0100 1
A 5 0101 1
A 6 0345 0
A 7 0232 1
A 8 0344 0
A 9 0345 1
A a 0101 1
A b 0233 1
A c 0344 1
A d 0100 1

// File: files.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_tag_lru.sv
rtl/cache_bank.sv
rtl/cache_dispatch.sv
rtl/cache_collect.sv
rtl/cache_top.sv
verif/cache_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f files.f --top-module cache_tb -o cache_sim
	out=$$(./obj_dir/cache_sim); echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
